// ==== src/bonk_settings.svh ====
`ifndef BONK_SETTINGS_SVH
`define BONK_SETTINGS_SVH

// clk cycles per quarter of a bit cell, 1 us at 50 MHz
`define QUARTER_CYCLES 50

// cycles between poll starts
`define POLL_INTERVAL 40000

// command bits plus stop bit
`define POLL_BITS 25
`define POLL_COMMAND 24'h400300

// controller answer length
`define REPORT_BITS 64

// line idle time that closes a response
`define RESPONSE_TIMEOUT (8 * `QUARTER_CYCLES)

// hit values above this get both fields halved
`define SCREAM_THRESHOLD 8'h35

`endif

// ==== src/bonkPkg.sv ====
`default_nettype none

`include "bonk_settings.svh"

package bonkPkg;

	// mapped controller report
	typedef struct packed {
		// bits 63..56 of the answer
		logic [7:0] hit;
		// microphone level, bits 11..0
		logic [11:0] scream;
	} report_t;

	// raw answer word, first received bit in the MSB
	typedef logic [`REPORT_BITS-1:0] raw_t;

	// poll encoder states
	typedef enum logic [1:0] {
		ENC_IDLE,
		ENC_SEND,
		ENC_LISTEN
	} encState_t;

endpackage

`default_nettype wire

// ==== src/frameIf.sv ====
`timescale 1ns/1ps
`default_nettype none

interface frameIf;
	// one-cycle strobe with the decoded bit
	logic bitValid;
	logic bitValue;
	// first falling edge of a response
	logic frameStart;
	// response closed by idle timeout
	logic frameEnd;

	modport decoder (
		output bitValid,
		output bitValue,
		output frameStart,
		output frameEnd
	);

	modport assembler (
		input bitValid,
		input bitValue,
		input frameStart,
		input frameEnd
	);
endinterface

`default_nettype wire

// ==== src/pollTimer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "bonk_settings.svh"

module pollTimer (
	input  logic clk,
	input  logic rst,
	output logic pollStart
);

	localparam int cntWidth = $clog2(`POLL_INTERVAL);

	logic [cntWidth-1:0] intervalCnt;

	// wraps every POLL_INTERVAL cycles, pulse on the wrap
	always_ff @(posedge clk) begin
		if (rst) begin
			intervalCnt <= '0;
			pollStart <= 1'b0;
		end else if (intervalCnt == cntWidth'(`POLL_INTERVAL - 1)) begin
			intervalCnt <= '0;
			pollStart <= 1'b1;
		end else begin
			intervalCnt <= intervalCnt + 1'b1;
			pollStart <= 1'b0;
		end
	end

	// a start is always a single-cycle pulse
	pollStartSingle: assert property (
		@(posedge clk) disable iff (rst)
		pollStart |=> !pollStart
	) else $error("pollStart held for more than one cycle");

endmodule

`default_nettype wire

// ==== src/pollEncoder.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "bonk_settings.svh"

module pollEncoder (
	input  logic clk,
	input  logic rst,
	input  logic pollStart,
	input  logic frameEnd,
	output logic dataDriveLow,
	output logic listen
);

	localparam int cmdBits = `POLL_BITS - 1;
	localparam int qWidth = $clog2(`QUARTER_CYCLES);
	localparam logic [cmdBits-1:0] pollCommand = `POLL_COMMAND;

	bonkPkg::encState_t state;
	logic [qWidth-1:0] quarterCnt;
	logic [1:0] quarterIdx;
	logic [4:0] bitIdx;

	logic lastQuarterCycle;
	logic lastQuarter;
	logic frameDone;
	logic [qWidth-1:0] nextQuarterCnt;
	logic [1:0] nextQuarterIdx;
	logic [4:0] nextBitIdx;
	logic nextBit;
	logic nextLow;

	// position in the frame one cycle ahead, so the output is a flop
	always_comb begin
		lastQuarterCycle = (quarterCnt == qWidth'(`QUARTER_CYCLES - 1));
		lastQuarter = lastQuarterCycle && (quarterIdx == 2'd3);
		frameDone = lastQuarter && (bitIdx == 5'(`POLL_BITS - 1));
		nextQuarterCnt = lastQuarterCycle ? '0 : quarterCnt + 1'b1;
		nextQuarterIdx = lastQuarterCycle ? quarterIdx + 1'b1 : quarterIdx;
		nextBitIdx = lastQuarter ? bitIdx + 1'b1 : bitIdx;
		// command MSB first, then the stop bit
		nextBit = (nextBitIdx < cmdBits) ? pollCommand[cmdBits - 1 - nextBitIdx] : 1'b1;
		// first quarter always low, middle quarters low only for a 0
		nextLow = (nextQuarterIdx == 2'd0) || (!nextBit && nextQuarterIdx != 2'd3);
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= bonkPkg::ENC_IDLE;
			quarterCnt <= '0;
			quarterIdx <= '0;
			bitIdx <= '0;
			dataDriveLow <= 1'b0;
		end else begin
			case (state)
				bonkPkg::ENC_IDLE: begin
					if (pollStart) begin
						state <= bonkPkg::ENC_SEND;
						quarterCnt <= '0;
						quarterIdx <= '0;
						bitIdx <= '0;
						dataDriveLow <= 1'b1;
					end
				end
				bonkPkg::ENC_SEND: begin
					if (frameDone) begin
						state <= bonkPkg::ENC_LISTEN;
						dataDriveLow <= 1'b0;
					end else begin
						quarterCnt <= nextQuarterCnt;
						quarterIdx <= nextQuarterIdx;
						bitIdx <= nextBitIdx;
						dataDriveLow <= nextLow;
					end
				end
				bonkPkg::ENC_LISTEN: begin
					if (frameEnd) begin
						state <= bonkPkg::ENC_IDLE;
					end
				end
				default: begin
					state <= bonkPkg::ENC_IDLE;
					dataDriveLow <= 1'b0;
				end
			endcase
		end
	end

	assign listen = (state == bonkPkg::ENC_LISTEN);

	// never pull the line while the decoder is listening
	noDriveWhileListen: assert property (
		@(posedge clk) disable iff (rst)
		!(dataDriveLow && listen)
	) else $error("dataDriveLow asserted during listen");

endmodule

`default_nettype wire

// ==== src/lineDecoder.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "bonk_settings.svh"

module lineDecoder (
	input  logic clk,
	input  logic rst,
	input  logic dataLine,
	input  logic listen,
	frameIf.decoder frame
);

	localparam int cntWidth = $clog2(`RESPONSE_TIMEOUT + 1);
	localparam logic [cntWidth-1:0] timeoutVal = cntWidth'(`RESPONSE_TIMEOUT);
	localparam logic [cntWidth-1:0] oneThreshold = cntWidth'(2 * `QUARTER_CYCLES);

	logic [1:0] syncQ;
	logic linePrev;
	logic lineNow;
	logic lineFall;
	logic lineRise;
	logic inFrame;
	logic [cntWidth-1:0] lowCnt;
	logic [cntWidth-1:0] highCnt;

	assign lineNow = syncQ[1];
	assign lineFall = linePrev && !lineNow;
	assign lineRise = !linePrev && lineNow;

	// two-flop synchronizer plus one flop for edge detection
	always_ff @(posedge clk) begin
		if (rst) begin
			syncQ <= 2'b11;
			linePrev <= 1'b1;
		end else begin
			syncQ <= {syncQ[0], dataLine};
			linePrev <= lineNow;
		end
	end

	always_ff @(posedge clk) begin
		if (rst || !listen) begin
			inFrame <= 1'b0;
			lowCnt <= '0;
			highCnt <= '0;
			frame.bitValid <= 1'b0;
			frame.bitValue <= 1'b0;
			frame.frameStart <= 1'b0;
			frame.frameEnd <= 1'b0;
		end else begin
			// low width, saturating
			if (!lineNow) begin
				if (lowCnt != timeoutVal) begin
					lowCnt <= lowCnt + 1'b1;
				end
			end else begin
				lowCnt <= '0;
			end

			// idle high time, saturating
			if (lineNow) begin
				if (highCnt != timeoutVal) begin
					highCnt <= highCnt + 1'b1;
				end
			end else begin
				highCnt <= '0;
			end

			if (lineFall) begin
				inFrame <= 1'b1;
			end
			frame.frameStart <= lineFall && !inFrame;

			// short low pulse is a 1
			frame.bitValid <= lineRise && inFrame;
			frame.bitValue <= lowCnt < oneThreshold;

			// timeout also releases the encoder when nobody answers
			frame.frameEnd <= lineNow && (highCnt == timeoutVal - 1'b1);
		end
	end

	// a start edge is a fall, a bit ends on a rise
	startNotBit: assert property (
		@(posedge clk) disable iff (rst)
		!(frame.bitValid && frame.frameStart)
	) else $error("bitValid and frameStart together");

endmodule

`default_nettype wire

// ==== src/reportAssembler.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "bonk_settings.svh"

module reportAssembler (
	input  logic clk,
	input  logic rst,
	frameIf.assembler frame,
	output bonkPkg::raw_t raw,
	output logic rawValid
);

	logic [6:0] bitCount;
	logic reportFull;

	assign reportFull = (bitCount == 7'(`REPORT_BITS));

	// bit count and completion strobe
	always_ff @(posedge clk) begin
		if (rst) begin
			bitCount <= '0;
			rawValid <= 1'b0;
		end else begin
			rawValid <= 1'b0;
			if (frame.frameStart || frame.frameEnd) begin
				// new frame or a dropped short one
				bitCount <= '0;
			end else if (frame.bitValid && !reportFull) begin
				bitCount <= bitCount + 1'b1;
				// the 64th bit completes the report
				if (bitCount == 7'(`REPORT_BITS - 1)) begin
					rawValid <= 1'b1;
				end
			end
		end
	end

	// payload bits only, first bit ends up in the MSB
	always_ff @(posedge clk) begin
		if (frame.bitValid && !reportFull && !frame.frameStart) begin
			raw <= {raw[`REPORT_BITS-2:0], frame.bitValue};
		end
	end

	// the stop bit and any extra bits never push the count past a report
	countBounded: assert property (
		@(posedge clk) disable iff (rst)
		bitCount <= 7'(`REPORT_BITS)
	) else $error("bit count overran the report length");

endmodule

`default_nettype wire

// ==== src/reportMapper.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "bonk_settings.svh"

module reportMapper (
	input  logic clk,
	input  logic rst,
	input  bonkPkg::raw_t raw,
	input  logic rawValid,
	output bonkPkg::report_t report,
	output logic reportValid
);

	logic [7:0] rawHit;
	logic [11:0] rawScream;
	bonkPkg::report_t mapped;

	// loud hits come in doubled, scale both fields back
	always_comb begin
		rawHit = raw[`REPORT_BITS-1 -: 8];
		rawScream = raw[11:0];
		if (rawHit > `SCREAM_THRESHOLD) begin
			mapped.hit = rawHit >> 1;
			mapped.scream = rawScream >> 1;
		end else begin
			mapped.hit = rawHit;
			mapped.scream = rawScream;
		end
	end

	// outputs hold until the next complete report
	always_ff @(posedge clk) begin
		if (rst) begin
			report <= '0;
			reportValid <= 1'b0;
		end else begin
			reportValid <= rawValid;
			if (rawValid) begin
				report <= mapped;
			end
		end
	end

endmodule

`default_nettype wire

// ==== src/bonkController.sv ====
`timescale 1ns/1ps
`default_nettype none

module bonkController (
	input  logic clk,
	input  logic rst,
	input  logic dataLine,
	output logic dataDriveLow,
	output logic [7:0] hit,
	output logic [11:0] scream,
	output logic reportValid
);

	logic pollStart;
	logic listen;
	bonkPkg::raw_t raw;
	logic rawValid;
	bonkPkg::report_t report;

	frameIf frameBus ();

	pollTimer timer0 (
		.clk(clk),
		.rst(rst),
		.pollStart(pollStart)
	);

	pollEncoder encoder0 (
		.clk(clk),
		.rst(rst),
		.pollStart(pollStart),
		.frameEnd(frameBus.frameEnd),
		.dataDriveLow(dataDriveLow),
		.listen(listen)
	);

	lineDecoder decoder0 (
		.clk(clk),
		.rst(rst),
		.dataLine(dataLine),
		.listen(listen),
		.frame(frameBus.decoder)
	);

	reportAssembler assembler0 (
		.clk(clk),
		.rst(rst),
		.frame(frameBus.assembler),
		.raw(raw),
		.rawValid(rawValid)
	);

	reportMapper mapper0 (
		.clk(clk),
		.rst(rst),
		.raw(raw),
		.rawValid(rawValid),
		.report(report),
		.reportValid(reportValid)
	);

	assign hit = report.hit;
	assign scream = report.scream;

endmodule

`default_nettype wire

// ==== dv/bonkDeviceModel.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "bonk_settings.svh"

module bonkDeviceModel (
	input  logic clk,
	input  logic line,
	input  bonkPkg::raw_t answer,
	input  int answerBits,
	input  logic silent,
	output logic driveLow,
	output int pollCount,
	output logic pollOk,
	output int pollSpan
);

	localparam int q = `QUARTER_CYCLES;

	// cycles the line holds one level, bounded by two bit cells
	task automatic measureLevel(input logic level, output int width);
		width = 0;
		while (line === level && width < 8 * q) begin
			width++;
			@(negedge clk);
		end
	endtask

	// one quarter low for a 1, three for a 0
	task automatic sendBit(input logic value);
		driveLow = 1'b1;
		repeat (value ? q : 3 * q) @(posedge clk);
		#1;
		driveLow = 1'b0;
		repeat (value ? 3 * q : q) @(posedge clk);
		#1;
	endtask

	initial begin
		logic [`POLL_BITS-1:0] cmd;
		int lowWidth;
		int highWidth;
		int span;
		int i;
		driveLow = 1'b0;
		pollCount = 0;
		pollOk = 1'b0;
		pollSpan = 0;
		forever begin
			@(negedge clk);
			if (line === 1'b0) begin
				cmd = '0;
				span = 0;
				for (i = 0; i < `POLL_BITS; i++) begin
					measureLevel(1'b0, lowWidth);
					span += lowWidth;
					cmd = {cmd[`POLL_BITS-2:0], lowWidth < 2 * q};
					// stop bit has no following low to end its high part
					if (i < `POLL_BITS - 1) begin
						measureLevel(1'b1, highWidth);
						span += highWidth;
					end
				end
				pollOk = (cmd[`POLL_BITS-1:1] == `POLL_COMMAND) && cmd[0];
				pollSpan = span;
				pollCount++;
				// rest of the stop bit, then the 2 us gap
				repeat (5 * q) @(posedge clk);
				#1;
				if (!silent) begin
					for (i = 0; i < answerBits; i++) begin
						sendBit(answer[`REPORT_BITS - 1 - i]);
					end
					if (answerBits >= `REPORT_BITS) begin
						sendBit(1'b1);
					end
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== dv/bonkControllerTb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "bonk_settings.svh"

module bonkControllerTb;

	// span from the first pull to the release of the stop bit
	localparam int pollSpanCycles = (4 * `POLL_BITS - 3) * `QUARTER_CYCLES;

	logic clk;
	logic rst;
	logic dataLine;
	logic dataDriveLow;
	logic devDriveLow;
	logic [7:0] hit;
	logic [11:0] scream;
	logic reportValid;
	bonkPkg::raw_t devAnswer;
	int devBits;
	logic devSilent;
	int pollCount;
	logic pollOk;
	int pollSpan;
	int valueErrors;
	int otherErrors;
	int reportCount;
	integer seed;
	bonkPkg::report_t lastReport;
	bonkPkg::report_t expectQ[$];
	string nameQ[$];

	// open-drain line is high unless either side pulls it down
	assign dataLine = !dataDriveLow && !devDriveLow;

	bonkController dut0 (
		.clk(clk),
		.rst(rst),
		.dataLine(dataLine),
		.dataDriveLow(dataDriveLow),
		.hit(hit),
		.scream(scream),
		.reportValid(reportValid)
	);

	bonkDeviceModel dev0 (
		.clk(clk),
		.line(dataLine),
		.answer(devAnswer),
		.answerBits(devBits),
		.silent(devSilent),
		.driveLow(devDriveLow),
		.pollCount(pollCount),
		.pollOk(pollOk),
		.pollSpan(pollSpan)
	);

	always #5 clk = !clk;

	// loud hits arrive doubled so both fields are halved
	function automatic bonkPkg::report_t expectReport(input bonkPkg::raw_t value);
		bonkPkg::report_t e;
		e.hit = value[63:56];
		e.scream = value[11:0];
		if (e.hit > `SCREAM_THRESHOLD) begin
			e.hit = e.hit >> 1;
			e.scream = e.scream >> 1;
		end
		return e;
	endfunction

	task automatic checkReport(input string name, input bonkPkg::report_t expected,
			input bonkPkg::report_t actual);
		if (actual !== expected) begin
			valueErrors++;
			$display("CHECK FAILED %s expected hit %02h scream %03h, actual hit %02h scream %03h",
				name, expected.hit, expected.scream, actual.hit, actual.scream);
		end
	endtask

	task automatic checkFlag(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			valueErrors++;
			$display("CHECK FAILED %s expected %b actual %b", name, expected, actual);
		end
	endtask

	task automatic checkCycles(input string name, input int expected, input int actual);
		if (actual != expected) begin
			valueErrors++;
			$display("CHECK FAILED %s expected %0d actual %0d", name, expected, actual);
		end
	endtask

	task automatic noteTimeout(input string what);
		otherErrors++;
		$display("timeout while waiting for %s", what);
	endtask

	// every reportValid is matched with the oldest pending report
	always @(negedge clk) begin
		if (!rst && reportValid) begin
			reportCount++;
			if (expectQ.size() == 0) begin
				otherErrors++;
				$display("reportValid pulsed while no report was pending");
			end else begin
				checkReport(nameQ.pop_front(), expectQ.pop_front(),
					bonkPkg::report_t'({hit, scream}));
			end
		end
	end

	// one poll and the answer to it
	task automatic runPoll(input string name, input bonkPkg::raw_t value, input int bits,
			input logic quiet);
		int startPolls;
		int startReports;
		int waited;
		logic full;
		@(posedge clk);
		#1;
		devAnswer = value;
		devBits = bits;
		devSilent = quiet;
		full = !quiet && bits >= `REPORT_BITS;
		startPolls = pollCount;
		startReports = reportCount;
		if (full) begin
			lastReport = expectReport(value);
			expectQ.push_back(lastReport);
			nameQ.push_back(name);
		end
		waited = 0;
		while (pollCount == startPolls && waited < 2 * `POLL_INTERVAL) begin
			@(negedge clk);
			waited++;
		end
		if (pollCount == startPolls) begin
			noteTimeout({name, " poll"});
		end
		checkFlag({name, " poll command"}, 1'b1, pollOk);
		checkCycles({name, " poll span"}, pollSpanCycles, pollSpan);
		waited = 0;
		if (full) begin
			while (reportCount == startReports && waited < `POLL_INTERVAL) begin
				@(negedge clk);
				waited++;
			end
			if (reportCount == startReports) begin
				noteTimeout({name, " reportValid"});
			end
		end else begin
			// the next poll starts only after the response window closed
			while (dataDriveLow !== 1'b1 && waited < `POLL_INTERVAL) begin
				@(negedge clk);
				waited++;
			end
			if (dataDriveLow !== 1'b1) begin
				noteTimeout({name, " next poll"});
			end
			checkCycles({name, " report count"}, startReports, reportCount);
			checkReport({name, " held outputs"}, lastReport,
				bonkPkg::report_t'({hit, scream}));
		end
	endtask

	initial begin
		bonkPkg::raw_t value;
		int waited;
		int i;
		logic sawValid;
		clk = 1'b0;
		rst = 1'b1;
		devAnswer = '0;
		devBits = `REPORT_BITS;
		devSilent = 1'b0;
		valueErrors = 0;
		otherErrors = 0;
		reportCount = 0;
		lastReport = '0;
		seed = 32'h4b0a_161b;
		repeat (16) @(posedge clk);
		#1;
		rst = 1'b0;
		checkFlag("drive after reset", 1'b0, dataDriveLow);

		// nothing happens before the first poll
		waited = 0;
		sawValid = 1'b0;
		while (dataDriveLow !== 1'b1 && waited < `POLL_INTERVAL + 10) begin
			@(negedge clk);
			waited++;
			sawValid = sawValid | reportValid;
		end
		if (dataDriveLow !== 1'b1) begin
			noteTimeout("first poll");
		end
		checkFlag("reportValid before first poll", 1'b0, sawValid);
		checkReport("outputs after reset", '0, bonkPkg::report_t'({hit, scream}));

		runPoll("low hit", 64'h2000_0000_0000_0abc, `REPORT_BITS, 1'b0);
		runPoll("all zero", 64'h0, `REPORT_BITS, 1'b0);
		runPoll("mixed body", 64'h1fa5_5a5a_a5a5_0123, `REPORT_BITS, 1'b0);
		runPoll("boundary 35", 64'h3500_0000_0000_0fff, `REPORT_BITS, 1'b0);
		runPoll("boundary 36", 64'h36ff_ffff_ffff_ffff, `REPORT_BITS, 1'b0);
		runPoll("max hit", 64'hff00_0000_0000_0801, `REPORT_BITS, 1'b0);
		for (i = 0; i < 20; i++) begin
			value = {$random(seed), $random(seed)};
			runPoll($sformatf("random %0d", i), value, `REPORT_BITS, 1'b0);
		end
		runPoll("silent device", 64'h7700_0000_0000_0111, `REPORT_BITS, 1'b1);
		runPoll("truncated 40", 64'h7f00_0000_0000_0222, 40, 1'b0);
		runPoll("after dropped frames", 64'h5a00_1234_5678_09ab, `REPORT_BITS, 1'b0);

		if (expectQ.size() != 0) begin
			otherErrors++;
			$display("%0d reports never arrived", expectQ.size());
		end
		$display("errors: %0d value mismatches, %0d other failures", valueErrors, otherErrors);
		if (valueErrors + otherErrors == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== bonkController.f ====
+incdir+src
src/bonkPkg.sv
src/frameIf.sv
src/pollTimer.sv
src/pollEncoder.sv
src/lineDecoder.sv
src/reportAssembler.sv
src/reportMapper.sv
src/bonkController.sv
dv/bonkDeviceModel.sv
dv/bonkControllerTb.sv

// ==== Bender.yml ====
package:
  name: bonk_controller

sources:
  - include_dirs:
      - src
    files:
      - src/bonkPkg.sv
      - src/frameIf.sv
      - src/pollTimer.sv
      - src/pollEncoder.sv
      - src/lineDecoder.sv
      - src/reportAssembler.sv
      - src/reportMapper.sv
      - src/bonkController.sv
  - target: test
    include_dirs:
      - src
    files:
      - dv/bonkDeviceModel.sv
      - dv/bonkControllerTb.sv
